// File: int_alu.sv
// Per-lane integer ALU stage
`timescale 1ns/1ps
`default_nettype none

module int_alu #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        in_valid,
    output logic                                        in_ready,
    input  int_pkg::ex_meta_t                           in_meta,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     op_a,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     op_b,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     op_b_raw,

    output logic                                        out_valid,
    input  logic                                        out_ready,
    output int_pkg::ex_meta_t                           out_meta,
    output logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     result
);
    import int_pkg::*;

    logic                           is_br;
    logic                           is_signed;
    logic                           br_static;
    logic                           cmp_raw;
    logic [NUM_LANES-1:0][XLEN-1:0] alu_res;
    logic                           accept;

    assign is_br     = in_meta.is_br;
    assign is_signed = in_meta.op.alu.is_signed; // Bit 2 in both op views
    assign br_static = in_meta.op.br.is_static;

    // Branch without immediate compares against rs2 itself
    assign cmp_raw = is_br & ~in_meta.use_imm;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] cmp_b;
        logic [XLEN:0]   sub_a;
        logic [XLEN:0]   sub_b;
        logic [XLEN:0]   sub_wide;  // Extra bit holds the less flag
        logic [XLEN:0]   shr_in;
        logic [XLEN-1:0] add_res;
        logic [XLEN-1:0] shr_res;
        logic [XLEN-1:0] msc_res;
        logic [XLEN-1:0] sub_res;
        logic [XLEN-1:0] cmp_res;

        assign a     = op_a[i];
        assign b     = op_b[i];
        assign cmp_b = cmp_raw ? op_b_raw[i] : b;

        assign add_res = a + b; // Also the jump target

        // 33-bit subtract, sign bit gives less-than
        assign sub_a    = {is_signed & a[XLEN-1], a};
        assign sub_b    = {is_signed & cmp_b[XLEN-1], cmp_b};
        assign sub_wide = sub_a - sub_b;

        assign sub_res = in_meta.op.alu.is_sub ? sub_wide[XLEN-1:0]
                                               : {{(XLEN-1){1'b0}}, sub_wide[XLEN]};

        // Equal in bit 1, less in bit 0
        assign cmp_res = {{(XLEN-2){1'b0}}, ~|sub_wide[XLEN-1:0], sub_wide[XLEN]};

        assign shr_in  = {is_signed & a[XLEN-1], a};
        assign shr_res = XLEN'($signed(shr_in) >>> b[SHIFT_BITS-1:0]);

        always_comb begin
            case (in_meta.op.alu.msc_sel)
                MSC_AND: msc_res = a & b;
                MSC_OR:  msc_res = a | b;
                MSC_XOR: msc_res = a ^ b;
                MSC_SLL: msc_res = a << b[SHIFT_BITS-1:0];
                default: msc_res = a & b;
            endcase
        end

        always_comb begin
            if (is_br) begin
                alu_res[i] = br_static ? add_res : cmp_res;
            end else begin
                case (in_meta.op.alu.op_class)
                    CLS_ADD: alu_res[i] = add_res;
                    CLS_SUB: alu_res[i] = sub_res;   // sub, slt, sltu
                    CLS_SHR: alu_res[i] = shr_res;
                    CLS_MSC: alu_res[i] = msc_res;
                    default: alu_res[i] = add_res;
                endcase
            end
        end
    end

    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_meta <= in_meta;
            result   <= alu_res;
        end
    end

endmodule

`default_nettype wire

// File: int_branch_commit.sv
// Commit stage with branch resolution
`timescale 1ns/1ps
`default_nettype none

module int_branch_commit #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        in_valid,
    output logic                                        in_ready,
    input  int_pkg::ex_meta_t                           in_meta,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     result,

    output logic                                        commit_valid,
    input  logic                                        commit_ready,
    output int_pkg::ex_meta_t                           commit_meta,
    output logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     commit_data,
    output int_pkg::branch_ctl_t                        branch_ctl
);
    import int_pkg::*;

    logic [NUM_LANES-1:0][XLEN-1:0] res_q;
    logic [XLEN-1:0]                br_res;
    logic [XLEN-1:0]                link_pc;
    logic                           is_static;
    logic                           br_fire;
    logic                           br_taken;
    logic [XLEN-1:0]                br_dest;
    logic                           accept;

    assign in_ready = ~commit_valid | commit_ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
        end else if (in_ready) begin
            commit_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit_meta <= in_meta;
            res_q       <= result;
        end
    end

    assign is_static = commit_meta.is_br & commit_meta.op.br.is_static;
    assign link_pc   = commit_meta.pc + XLEN'(4);

    // Jumps write the return address in every lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            commit_data[i] = is_static ? link_pc : res_q[i];
        end
    end

    // Lane tid carries the deciding compare
    always_comb begin
        br_res = res_q[0];
        for (int i = 1; i < NUM_LANES; i++) begin
            if (commit_meta.tid == TID_BITS'(i)) begin
                br_res = res_q[i];
            end
        end
    end

    // Resolve only on the last commit of the instruction
    assign br_fire = commit_valid & commit_ready & commit_meta.is_br & commit_meta.eop;

    assign br_taken = commit_meta.op.br.is_static
                    | ((commit_meta.op.br.is_less ? br_res[0] : br_res[1])
                       ^ commit_meta.op.br.is_neg);
    assign br_dest  = commit_meta.op.br.is_static ? br_res
                                                  : commit_meta.pc + commit_meta.imm;

    // One cycle behind the commit transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            branch_ctl.valid <= 1'b0;
        end else begin
            branch_ctl.valid <= br_fire;
        end
        branch_ctl.wid   <= commit_meta.wid;
        branch_ctl.taken <= br_taken;
        branch_ctl.dest  <= br_dest;
    end

endmodule

`default_nettype wire

// File: int_exec_top.sv
// Integer execute pipeline top
`timescale 1ns/1ps
`default_nettype none

module int_exec_top #(
    parameter int NUM_LANES = 4 // 1, 2 or 4
) (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        in_valid,
    output logic                                        in_ready,
    input  int_pkg::ex_meta_t                           in_meta,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     in_rs1,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     in_rs2,

    output logic                                        commit_valid,
    input  logic                                        commit_ready,
    output int_pkg::ex_meta_t                           commit_meta,
    output logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     commit_data,
    output int_pkg::branch_ctl_t                        branch_ctl
);
    import int_pkg::*;

    // Operand select to ALU
    logic                           sel_valid;
    logic                           sel_ready;
    ex_meta_t                       sel_meta;
    logic [NUM_LANES-1:0][XLEN-1:0] sel_a;
    logic [NUM_LANES-1:0][XLEN-1:0] sel_b;
    logic [NUM_LANES-1:0][XLEN-1:0] sel_b_raw;

    // ALU to commit
    logic                           alu_valid;
    logic                           alu_ready;
    ex_meta_t                       alu_meta;
    logic [NUM_LANES-1:0][XLEN-1:0] alu_result;

    int_operand_sel #(
        .NUM_LANES (NUM_LANES)
    ) u_operand_sel (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_meta   (in_meta),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .out_valid (sel_valid),
        .out_ready (sel_ready),
        .out_meta  (sel_meta),
        .op_a      (sel_a),
        .op_b      (sel_b),
        .op_b_raw  (sel_b_raw)
    );

    int_alu #(
        .NUM_LANES (NUM_LANES)
    ) u_alu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .in_meta   (sel_meta),
        .op_a      (sel_a),
        .op_b      (sel_b),
        .op_b_raw  (sel_b_raw),
        .out_valid (alu_valid),
        .out_ready (alu_ready),
        .out_meta  (alu_meta),
        .result    (alu_result)
    );

    int_branch_commit #(
        .NUM_LANES (NUM_LANES)
    ) u_branch_commit (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (alu_valid),
        .in_ready     (alu_ready),
        .in_meta      (alu_meta),
        .result       (alu_result),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_meta  (commit_meta),
        .commit_data  (commit_data),
        .branch_ctl   (branch_ctl)
    );

endmodule

`default_nettype wire

// File: int_operand_sel.sv
// Operand select stage
`timescale 1ns/1ps
`default_nettype none

module int_operand_sel #(
    parameter int NUM_LANES = 4
) (
    input  logic                                        clk,
    input  logic                                        rst,

    input  logic                                        in_valid,
    output logic                                        in_ready,
    input  int_pkg::ex_meta_t                           in_meta,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     in_rs1,
    input  logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     in_rs2,

    output logic                                        out_valid,
    input  logic                                        out_ready,
    output int_pkg::ex_meta_t                           out_meta,
    output logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     op_a,
    output logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     op_b,
    output logic [NUM_LANES-1:0][int_pkg::XLEN-1:0]     op_b_raw
);
    import int_pkg::*;

    logic [NUM_LANES-1:0][XLEN-1:0] sel_a;
    logic [NUM_LANES-1:0][XLEN-1:0] sel_b;
    logic                           take_pc;
    logic                           take_imm;
    logic                           accept;

    // Operand sources, same rule for ALU ops and branches
    assign take_pc  = in_meta.use_pc;  // auipc, jal
    assign take_imm = in_meta.use_imm; // I-type, lui, jal, jalr

    // PC and immediate are broadcast to every lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            sel_a[i] = take_pc  ? in_meta.pc  : in_rs1[i];
            sel_b[i] = take_imm ? in_meta.imm : in_rs2[i];
        end
    end

    // Stage register can take a new item when empty or draining
    assign in_ready = ~out_valid | out_ready;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload, loaded only on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            out_meta <= in_meta;
            op_a     <= sel_a;
            op_b     <= sel_b;
            op_b_raw <= in_rs2; // Branch compare source
        end
    end

endmodule

`default_nettype wire

// File: int_pkg.sv
// Integer execute shared types
`default_nettype none

package int_pkg;

    localparam int XLEN       = 32; // Data word width
    localparam int SHIFT_BITS = 5;
    localparam int WID_BITS   = 2;  // Warp id
    localparam int RD_BITS    = 5;  // Destination register number
    localparam int TID_BITS   = 2;  // Lane index, covers up to 4 lanes

    // Result class of an ALU op
    typedef enum logic [1:0] {
        CLS_ADD = 2'd0, // add, lui, auipc
        CLS_SUB = 2'd1, // sub and set-less-than
        CLS_SHR = 2'd2, // srl, sra
        CLS_MSC = 2'd3  // logic ops and sll
    } op_class_e;

    // msc_sel encodings within CLS_MSC
    localparam logic [1:0] MSC_AND = 2'd0;
    localparam logic [1:0] MSC_OR  = 2'd1;
    localparam logic [1:0] MSC_XOR = 2'd2;
    localparam logic [1:0] MSC_SLL = 2'd3;

    typedef struct packed {
        op_class_e  op_class;
        logic       is_sub;    // Clear on CLS_SUB means set-less-than
        logic       is_signed;
        logic [1:0] msc_sel;
    } alu_op_t;

    typedef struct packed {
        logic       is_static; // jal / jalr
        logic       is_less;   // Compare on less instead of equal
        logic       is_neg;    // Invert the compare outcome
        logic       is_signed;
        logic [1:0] spare;
    } br_op_t;

    // Same op word, decoded by is_br
    typedef union packed {
        alu_op_t alu;
        br_op_t  br;
    } op_code_u;

    typedef struct packed {
        logic [7:0]          uuid;
        logic [WID_BITS-1:0] wid;
        logic [3:0]          tmask;
        logic [RD_BITS-1:0]  rd;
        logic                wb;
        logic [TID_BITS-1:0] tid;  // Lane that resolves a branch
        logic                sop;
        logic                eop;
        logic                is_br;
        op_code_u            op;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     imm;
        logic                use_pc;
        logic                use_imm;
    } ex_meta_t;

    // Branch resolution pulse back to the scheduler
    typedef struct packed {
        logic                valid;
        logic [WID_BITS-1:0] wid;
        logic                taken;
        logic [XLEN-1:0]     dest;
    } branch_ctl_t;

endpackage

`default_nettype wire

// File: sources.f
+incdir+.
int_pkg.sv
int_operand_sel.sv
int_alu.sv
int_branch_commit.sv
int_exec_top.sv
tb_int_exec.sv

// File: tb_int_model.svh
// Execute pipeline reference model
`ifndef TB_INT_MODEL_SVH
`define TB_INT_MODEL_SVH

// One expected commit with its branch outcome
typedef struct packed {
    ex_meta_t                       meta;
    logic [NUM_LANES-1:0][XLEN-1:0] data;
    logic                           taken;
    logic [XLEN-1:0]                dest;
    logic                           lat_chk; // Full-rate run, latency is exact
    logic [31:0]                    acc_cyc;
} expect_t;

// Lane result from the op rules, operand selection included
function automatic logic [XLEN-1:0] lane_result(input ex_meta_t m,
                                                 input logic [XLEN-1:0] rs1,
                                                 input logic [XLEN-1:0] rs2);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            sgn;
    logic            lt;
    a   = m.use_pc ? m.pc : rs1;
    b   = m.use_imm ? m.imm : rs2;
    sgn = m.is_br ? m.op.br.is_signed : m.op.alu.is_signed;
    lt  = sgn ? ($signed(a) < $signed(b)) : (a < b);
    if (m.is_br) begin
        return m.op.br.is_static ? a + b : {30'd0, a == b, lt}; // Equal bit 1, less bit 0
    end
    case (m.op.alu.op_class)
        CLS_ADD: return a + b;
        CLS_SUB: return m.op.alu.is_sub ? a - b : {31'd0, lt};
        CLS_SHR: begin
            if (m.op.alu.is_signed) begin
                return $signed(a) >>> b[SHIFT_BITS-1:0];
            end
            return a >> b[SHIFT_BITS-1:0];
        end
        default: begin
            case (m.op.alu.msc_sel)
                MSC_AND: return a & b;
                MSC_OR:  return a | b;
                MSC_XOR: return a ^ b;
                default: return a << b[SHIFT_BITS-1:0];
            endcase
        end
    endcase
endfunction

// Branch outcome straight from the deciding lane's operands
function automatic logic branch_taken(input ex_meta_t m,
                                      input logic [XLEN-1:0] rs1,
                                      input logic [XLEN-1:0] rs2);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            cond;
    a = m.use_pc ? m.pc : rs1;
    b = m.use_imm ? m.imm : rs2;
    if (m.op.br.is_static) begin
        return 1'b1; // jal, jalr
    end
    if (!m.op.br.is_less) begin
        cond = (a == b);                 // beq, bne
    end else if (m.op.br.is_signed) begin
        cond = ($signed(a) < $signed(b)); // blt, bge
    end else begin
        cond = (a < b);                  // bltu, bgeu
    end
    return m.op.br.is_neg ? !cond : cond;
endfunction

// Expected record for an accepted instruction
function automatic expect_t expect_instr(input ex_meta_t m,
                                         input logic [NUM_LANES-1:0][XLEN-1:0] rs1,
                                         input logic [NUM_LANES-1:0][XLEN-1:0] rs2,
                                         input int acc, input logic lat_chk);
    expect_t         e;
    logic [XLEN-1:0] r;
    e.meta    = m;
    e.lat_chk = lat_chk;
    e.acc_cyc = acc;
    for (int i = 0; i < NUM_LANES; i++) begin
        e.data[i] = (m.is_br && m.op.br.is_static) ? m.pc + 32'd4  // Link address
                                                   : lane_result(m, rs1[i], rs2[i]);
    end
    r       = lane_result(m, rs1[m.tid], rs2[m.tid]);
    e.taken = branch_taken(m, rs1[m.tid], rs2[m.tid]);
    e.dest  = m.op.br.is_static ? r : m.pc + m.imm;
    return e;
endfunction

`endif

// File: tb_int_exec.sv
// Integer execute pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_int_exec;
    import int_pkg::*;

    localparam int NUM_LANES = 4;
    localparam int TIMEOUT   = 5000; // Cycles per wait loop

    `include "tb_int_model.svh"

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           in_valid, in_ready, commit_valid, commit_ready;
    ex_meta_t                       in_meta, commit_meta;
    logic [NUM_LANES-1:0][XLEN-1:0] in_rs1, in_rs2, commit_data;
    branch_ctl_t                    branch_ctl;

    expect_t exp_q[$];
    expect_t br_exp;   // Branch waiting for its pulse
    bit      br_pend;
    bit      offer;
    int      mode;     // 0 ALU, 1 branch, 2 jump, 3 stalls, 4 full rate
    int      stall, cyc, n_acc, n_commit, errors, tests, failed_tests;

    int_exec_top #(.NUM_LANES(NUM_LANES)) UUT (.*);

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic offer_instr();
        logic [127:0]                   rnd;
        ex_meta_t                       m;
        logic [NUM_LANES-1:0][XLEN-1:0] r1;
        logic [NUM_LANES-1:0][XLEN-1:0] r2;
        int                             kind;
        kind      = (mode < 3) ? mode : $urandom_range(2);
        rnd       = {$urandom, $urandom, $urandom, $urandom};
        m         = rnd[$bits(ex_meta_t)-1:0];
        m.pc[1:0] = 2'b00;
        m.is_br   = (kind != 0);
        if (kind == 1) begin
            m.op.br.is_static = 1'b0;
            m.use_pc          = 1'b0;
            m.use_imm         = 1'b0;
        end else if (kind == 2) begin
            m.op.br.is_static = 1'b1; // use_pc picks jal over jalr
            m.use_imm         = 1'b1;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            r1[i] = $urandom;
            r2[i] = ($urandom_range(3) == 0) ? r1[i] : $urandom; // Equal operands now and then
        end
        in_valid <= 1'b1;
        in_meta  <= m;
        in_rs1   <= r1;
        in_rs2   <= r2;
    endtask

    // Sample and check on the edge then drive the next inputs
    task automatic step();
        expect_t e;
        @(posedge clk);
        cyc++;
        check_value("branch_ctl.valid", branch_ctl.valid, br_pend);
        if (br_pend) begin
            check_value("branch_ctl.wid", branch_ctl.wid, br_exp.meta.wid);
            check_value("branch_ctl.taken", branch_ctl.taken, br_exp.taken);
            check_value("branch_ctl.dest", branch_ctl.dest, br_exp.dest);
        end
        br_pend = 1'b0;
        if (mode == 4 && offer) begin
            check_value("in_ready", in_ready, 1'b1);
        end
        if (in_valid && in_ready) begin
            exp_q.push_back(expect_instr(in_meta, in_rs1, in_rs2, cyc, mode == 4));
            n_acc++;
        end
        if (commit_valid && commit_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Commit at %0t ns arrived with no instruction outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                n_commit++;
                check_value("commit_meta", commit_meta, e.meta);
                for (int i = 0; i < NUM_LANES; i++) begin
                    check_value($sformatf("commit_data[%0d]", i), commit_data[i], e.data[i]);
                end
                if (e.lat_chk) begin
                    check_value("commit latency", cyc - e.acc_cyc, 3);
                end
                br_pend = e.meta.is_br & e.meta.eop;
                br_exp  = e;
            end
        end
        if (!in_valid || in_ready) begin // Held until taken
            if (offer && (mode == 4 || $urandom_range(9) < 7)) begin
                offer_instr();
            end else begin
                in_valid <= 1'b0;
            end
        end
        if (mode == 3 && stall > 0) begin
            stall--;
            commit_ready <= 1'b0;
        end else if (mode >= 3) begin
            commit_ready <= 1'b1;
            if (mode == 3 && $urandom_range(7) == 0) begin
                stall = $urandom_range(30, 5); // Long stall ahead
            end
        end else begin
            commit_ready <= ($urandom_range(3) != 0);
        end
    endtask

    task automatic run_test(input int kind, input int count, input string name);
        int start_err;
        int target;
        int wait_cyc;
        start_err = errors;
        target    = n_acc + count;
        mode      = kind;
        offer     = 1'b1;
        wait_cyc  = 0;
        while (n_acc < target && wait_cyc < TIMEOUT) begin
            step();
            wait_cyc++;
        end
        if (n_acc < target) begin
            errors++;
            $display("Timeout in %s with %0d instructions still not accepted", name,
                     target - n_acc);
        end
        offer    = 1'b0;
        wait_cyc = 0;
        while ((exp_q.size() > 0 || in_valid || br_pend) && wait_cyc < TIMEOUT) begin
            step();
            wait_cyc++;
        end
        if (wait_cyc >= TIMEOUT) begin
            errors++;
            $display("Timeout in %s because the pipeline did not drain", name);
        end
        check_value("commit count", n_commit, n_acc);
        tests++;
        if (errors != start_err) begin
            failed_tests++;
        end
        $display("%s done with %0d errors", name, errors - start_err);
    endtask

    initial begin
        void'($urandom(33));
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_meta      = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        commit_ready = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("commit_valid", commit_valid, 1'b0);
        check_value("branch_ctl.valid", branch_ctl.valid, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
        tests++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("reset done with %0d errors", errors);
        run_test(0, 300, "alu ops");
        run_test(1, 200, "conditional branches");
        run_test(2, 100, "static jumps");
        run_test(3, 300, "commit stalls");
        run_test(4, 200, "full rate");
        $display("%0d tests, %0d failed, %0d errors, %0d commits",
                 tests, failed_tests, errors, n_commit);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
